//--- verilog/asg_pkg.sv
// shared localparams, sample and pointer types, register map and channel state enums
`default_nettype none

package asg_pkg;

  ////////////////////////////////////////
  // sizes
  ////////////////////////////////////////

  localparam int NCH = 2;          // channels
  localparam int CWM = 8;          // pointer integer bits, 256 entry table
  localparam int CWF = 8;          // pointer fraction bits
  localparam int CPW = CWM + CWF;  // full pointer
  localparam int CWL = 16;         // burst length counter
  localparam int CWN = 8;          // burst repetition counter
  localparam int DW  = 14;         // DAC sample
  localparam int AW  = 11;         // bus address

  // bit positions inside REG_CTL and REG_BCF writes
  localparam int CTL_STR = 0;
  localparam int CTL_STP = 1;
  localparam int CTL_TRG = 2;
  localparam int BCF_BEN = 0;
  localparam int BCF_INF = 1;

  typedef logic [DW-1:0]  sample_t;
  typedef logic [CPW-1:0] ptr_t;

  // siz after reset, the whole table
  localparam ptr_t SIZ_FULL = '1;

  // register codes, low 9 address bits
  typedef enum logic [AW-3:0] {
    REG_CTL = 9'd0,
    REG_SIZ = 9'd1,
    REG_STE = 9'd2,
    REG_OFF = 9'd3,
    REG_BCF = 9'd4,
    REG_BDL = 9'd5,
    REG_BLN = 9'd6,
    REG_BNM = 9'd7
  } reg_e;

  typedef enum logic [1:0] {ST_IDLE, ST_ARMED, ST_DATA, ST_GAP} chan_state_e;

endpackage

`default_nettype wire

//--- verilog/asg_cfg_if.sv
// per-channel configuration, control strobes and table write port
`timescale 1ns/1ps
`default_nettype none

interface asg_cfg_if import asg_pkg::*; ();

  // periodic mode, fixed point
  ptr_t           siz;
  ptr_t           ste;
  ptr_t           off;
  // burst mode
  logic           ben;
  logic           inf;
  logic [CWL-1:0] bdl;
  logic [CWL-1:0] bln;
  logic [CWN-1:0] bnm;
  // single cycle strobes
  logic           str;
  logic           stp;
  logic           trg_sw;
  // table write port
  logic           tbl_we;
  logic [CWM-1:0] tbl_addr;
  sample_t        tbl_data;

  modport regs (output siz, ste, off, ben, inf, bdl, bln, bnm,
                output str, stp, trg_sw, tbl_we, tbl_addr, tbl_data);
  modport chan (input siz, ste, off, ben, inf, bdl, bln, bnm,
                input str, stp, trg_sw, tbl_we, tbl_addr, tbl_data);

endinterface

`default_nettype wire

//--- verilog/asg_stream_if.sv
// sample stream with data, valid, ready and last
`timescale 1ns/1ps
`default_nettype none

interface asg_stream_if import asg_pkg::*; ();

  sample_t data;
  logic    valid;
  logic    ready;
  // final beat of a finite burst
  logic    last;

  // beat moves when valid and ready are both high
  modport src (output data, valid, last, input ready);
  modport snk (input data, valid, last, output ready);

endinterface

`default_nettype wire

//--- verilog/asg_regs.sv
// bus decoder: table writes, channel config registers and control strobes
`timescale 1ns/1ps
`default_nettype none

module asg_regs import asg_pkg::*; (
  input  logic          sto,
  input  logic          ctl_rst,
  input  logic          bus_wen,
  input  logic [AW-1:0] bus_addr,
  input  logic [31:0]   bus_wdata,
  asg_cfg_if.regs       cfg [NCH]
);

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  // addr[10] channel, addr[9] region (1 = table), addr[8:0] index or code
  logic bus_tbl;
  reg_e bus_reg;

  assign bus_tbl = bus_addr[AW-2];
  assign bus_reg = reg_e'(bus_addr[AW-3:0]);

  ////////////////////////////////////////
  // per channel registers
  ////////////////////////////////////////

  for (genvar i = 0; i < NCH; i++) begin : g_ch
    logic sel;
    logic wen_reg;
    logic wen_tbl;

    // channel hit
    assign sel     = bus_wen & (bus_addr[AW-1] == 1'(i));
    assign wen_reg = sel & ~bus_tbl;
    assign wen_tbl = sel & bus_tbl;

    // config levels, siz starts at full table
    always_ff @(posedge sto) begin
      if (ctl_rst) begin
        cfg[i].siz <= SIZ_FULL;
        cfg[i].ste <= '0;
        cfg[i].off <= '0;
        cfg[i].ben <= 1'b0;
        cfg[i].inf <= 1'b0;
        cfg[i].bdl <= '0;
        cfg[i].bln <= '0;
        cfg[i].bnm <= '0;
      end else if (wen_reg) begin
        case (bus_reg)
          REG_SIZ: cfg[i].siz <= bus_wdata[CPW-1:0];
          REG_STE: cfg[i].ste <= bus_wdata[CPW-1:0];
          REG_OFF: cfg[i].off <= bus_wdata[CPW-1:0];
          REG_BCF: begin
            cfg[i].ben <= bus_wdata[BCF_BEN];
            cfg[i].inf <= bus_wdata[BCF_INF];
          end
          REG_BDL: cfg[i].bdl <= bus_wdata[CWL-1:0];
          REG_BLN: cfg[i].bln <= bus_wdata[CWL-1:0];
          REG_BNM: cfg[i].bnm <= bus_wdata[CWN-1:0];
          // REG_CTL handled below as strobes
          default: ;
        endcase
      end
    end

    // strobes, high for one cycle only
    always_ff @(posedge sto) begin
      if (ctl_rst) begin
        cfg[i].str    <= 1'b0;
        cfg[i].stp    <= 1'b0;
        cfg[i].trg_sw <= 1'b0;
        cfg[i].tbl_we <= 1'b0;
      end else begin
        cfg[i].str    <= wen_reg & (bus_reg == REG_CTL) & bus_wdata[CTL_STR];
        cfg[i].stp    <= wen_reg & (bus_reg == REG_CTL) & bus_wdata[CTL_STP];
        cfg[i].trg_sw <= wen_reg & (bus_reg == REG_CTL) & bus_wdata[CTL_TRG];
        cfg[i].tbl_we <= wen_tbl;
      end
    end

    // table write payload
    always_ff @(posedge sto) begin
      cfg[i].tbl_addr <= bus_addr[CWM-1:0];
      cfg[i].tbl_data <= bus_wdata[DW-1:0];
    end
  end

endmodule

`default_nettype wire

//--- verilog/asg_channel.sv
// one generator channel: sample table, phase pointer, burst counters, FSM, output pipeline
`timescale 1ns/1ps
`default_nettype none

module asg_channel import asg_pkg::*; (
  input  logic           sto,
  input  logic           ctl_rst,
  input  logic           trg_ext,
  asg_cfg_if.chan        cfg,
  asg_stream_if.src      sto_s,
  output logic           evn_per,
  output logic           evn_lst,
  output logic           sts_run,
  output logic [CWN-1:0] sts_bnm
);

  sample_t        tbl [2**CWM];
  chan_state_e    state;
  // pointer
  ptr_t           ptr;
  ptr_t           ptr_cur;
  logic [CPW:0]   ptr_sum;
  logic [CPW:0]   ptr_sub;
  ptr_t           ptr_nxt;
  // burst counters, registered and effective for this beat
  logic [CWL-1:0] cnt_bln;
  logic [CWL-1:0] cur_bln;
  logic [CWN-1:0] cnt_bnm;
  logic [CWN-1:0] cur_bnm;
  logic           end_bdl;
  logic           end_bln;
  logic           end_bnm;
  // beat control
  logic           adv;
  logic           acc;
  logic           beat;
  logic           rd;
  logic           lst;
  // pipeline stages
  logic [CWM-1:0] raddr;
  logic           v1;
  logic           r1;
  logic           l1;
  sample_t        rdata;
  logic           v2;
  logic           l2;

  ////////////////////////////////////////
  // sample table
  ////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (cfg.tbl_we) begin
      tbl[cfg.tbl_addr] <= cfg.tbl_data;
    end
  end

  ////////////////////////////////////////
  // beat generation
  ////////////////////////////////////////

  // whole pipeline moves when the output slot frees
  assign adv  = sto_s.ready | ~sto_s.valid;
  assign acc  = (state == ST_ARMED) & (cfg.trg_sw | trg_ext) & adv & ~cfg.stp;
  // the accepted trigger is itself the first data beat
  assign beat = adv & ~cfg.stp & (acc | (state == ST_DATA) | (state == ST_GAP));
  assign rd   = acc | (state == ST_DATA);

  assign cur_bln = acc ? '0 : cnt_bln;
  assign cur_bnm = acc ? '0 : cnt_bnm;
  assign end_bdl = (cur_bln == cfg.bdl);
  // periods only exist in burst mode
  assign end_bln = cfg.ben & (cur_bln == cfg.bln);
  assign end_bnm = (cur_bnm == cfg.bnm) & ~cfg.inf;
  assign lst     = end_bln & end_bnm;

  // modulo step, result kept below siz+1
  assign ptr_cur = acc ? cfg.off : ptr;
  assign ptr_sum = {1'b0, ptr_cur} + {1'b0, cfg.ste} + 1'b1;
  assign ptr_sub = ptr_sum - {1'b0, cfg.siz} - 1'b1;
  assign ptr_nxt = ptr_sub[CPW] ? ptr_sum[CPW-1:0] : ptr_sub[CPW-1:0];

  ////////////////////////////////////////
  // state machine and counters
  ////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      state   <= ST_IDLE;
      ptr     <= '0;
      cnt_bln <= '0;
      cnt_bnm <= '0;
    end else if (cfg.stp) begin
      state <= ST_IDLE;
    end else if (state == ST_IDLE) begin
      if (cfg.str) begin
        state <= ST_ARMED;
      end
    end else if (beat) begin
      if (lst) begin
        state <= ST_IDLE;
      end else if (end_bln) begin
        // next period restarts at the offset
        state   <= ST_DATA;
        ptr     <= cfg.off;
        cnt_bln <= '0;
        cnt_bnm <= cur_bnm + CWN'(!cfg.inf);
      end else begin
        if ((state == ST_GAP) || (cfg.ben && end_bdl)) begin
          state <= ST_GAP;
        end else begin
          state <= ST_DATA;
        end
        if (rd) begin
          ptr <= ptr_nxt;
        end
        cnt_bln <= cur_bln + 1'b1;
        cnt_bnm <= cur_bnm;
      end
    end
  end

  ////////////////////////////////////////
  // pipeline: address, read, output
  ////////////////////////////////////////

  // stop flushes beats in flight
  always_ff @(posedge sto) begin
    if (ctl_rst || cfg.stp) begin
      v1 <= 1'b0;
      r1 <= 1'b0;
      l1 <= 1'b0;
      v2 <= 1'b0;
      l2 <= 1'b0;
    end else if (adv) begin
      v1 <= beat;
      r1 <= beat & rd;
      l1 <= beat & lst;
      v2 <= v1;
      l2 <= l1;
    end
  end

  // gap beats skip the read so rdata repeats the last sample
  always_ff @(posedge sto) begin
    if (adv) begin
      if (beat && rd) begin
        raddr <= ptr_cur[CPW-1:CWF];
      end
      if (r1) begin
        rdata <= tbl[raddr];
      end
      if (v2) begin
        sto_s.data <= rdata;
      end
    end
  end

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      sto_s.valid <= 1'b0;
      sto_s.last  <= 1'b0;
    end else if (adv) begin
      sto_s.valid <= v2 & ~cfg.stp;
      sto_s.last  <= l2 & ~cfg.stp;
    end
  end

  ////////////////////////////////////////
  // events and status
  ////////////////////////////////////////

  // period end, seen when its last beat is generated
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      evn_per <= 1'b0;
    end else begin
      evn_per <= beat & end_bln;
    end
  end

  assign evn_lst = sto_s.valid & sto_s.ready & sto_s.last;
  // running until the last beat has left
  assign sts_run = (state == ST_DATA) | (state == ST_GAP) | v1 | v2 | sto_s.valid;
  assign sts_bnm = cnt_bnm;

  // stalled beat must not change
  a_hold: assert property (@(posedge sto) disable iff (ctl_rst)
    sto_s.valid && !sto_s.ready |=> $stable(sto_s.data) && $stable(sto_s.last));

  // table index stays inside the configured size
  a_ptr: assert property (@(posedge sto) disable iff (ctl_rst)
    (state != ST_IDLE) |-> (ptr[CPW-1:CWF] <= cfg.siz[CPW-1:CWF]));

endmodule

`default_nettype wire

//--- verilog/asg_dac_mux.sv
// DAC output stage: one lane per channel, holds the level of idle channels
`timescale 1ns/1ps
`default_nettype none

module asg_dac_mux import asg_pkg::*; (
  input  logic              sto,
  input  logic              ctl_rst,
  asg_stream_if.snk         chs [NCH],
  input  logic              dac_ready,
  output logic [NCH*DW-1:0] dac_data,
  output logic [NCH-1:0]    dac_vld,
  output logic [NCH-1:0]    dac_last
);

  ////////////////////////////////////////
  // lanes
  ////////////////////////////////////////

  for (genvar i = 0; i < NCH; i++) begin : g_lane
    sample_t lane;
    logic    vld;
    logic    lst;

    // single ready for all channels
    assign chs[i].ready = dac_ready;

    // vld marks a beat taken this cycle
    always_ff @(posedge sto) begin
      if (ctl_rst) begin
        vld <= 1'b0;
        lst <= 1'b0;
      end else begin
        vld <= chs[i].valid & dac_ready;
        lst <= chs[i].valid & dac_ready & chs[i].last;
      end
    end

    // not valid, keep the previous level
    always_ff @(posedge sto) begin
      if (chs[i].valid && dac_ready) begin
        lane <= chs[i].data;
      end
    end

    assign dac_data[i*DW +: DW] = lane;
    assign dac_vld[i]           = vld;
    assign dac_last[i]          = lst;

    a_last: assert property (@(posedge sto) disable iff (ctl_rst)
      $rose(dac_last[i]) |-> dac_vld[i]);
  end

endmodule

`default_nettype wire

//--- verilog/asg_top.sv
// top level: register decoder, channel engines and DAC stage
`timescale 1ns/1ps
`default_nettype none

module asg_top import asg_pkg::*; (
  input  logic              sto,
  input  logic              ctl_rst,
  // register bus, write only
  input  logic              bus_wen,
  input  logic [AW-1:0]     bus_addr,
  input  logic [31:0]       bus_wdata,
  // shared external trigger
  input  logic              trg_ext,
  // DAC word
  input  logic              dac_ready,
  output logic [NCH*DW-1:0] dac_data,
  output logic [NCH-1:0]    dac_vld,
  output logic [NCH-1:0]    dac_last,
  // per channel events and status
  output logic [NCH-1:0]    evn_per,
  output logic [NCH-1:0]    evn_lst,
  output logic [NCH-1:0]    sts_run
);

  asg_cfg_if    cfg [NCH] ();
  asg_stream_if chs [NCH] ();

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  asg_regs u_regs (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .bus_wen   (bus_wen),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .cfg       (cfg)
  );

  ////////////////////////////////////////
  // channels
  ////////////////////////////////////////

  for (genvar i = 0; i < NCH; i++) begin : g_ch
    asg_channel u_ch (
      .sto     (sto),
      .ctl_rst (ctl_rst),
      .trg_ext (trg_ext),
      .cfg     (cfg[i]),
      .sto_s   (chs[i]),
      .evn_per (evn_per[i]),
      .evn_lst (evn_lst[i]),
      .sts_run (sts_run[i]),
      .sts_bnm ()
    );
  end

  // DAC stage
  asg_dac_mux u_dac (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .chs       (chs),
    .dac_ready (dac_ready),
    .dac_data  (dac_data),
    .dac_vld   (dac_vld),
    .dac_last  (dac_last)
  );

endmodule

`default_nettype wire

//--- dv/asg_tb.sv
// testbench: clock, reset, bus tasks, pointer and burst model, checks, watchdog, summary
`timescale 1ns/1ps
`default_nettype none

module asg_tb import asg_pkg::*; ();

  logic              sto = 1'b0;
  logic              ctl_rst;
  logic              bus_wen;
  logic [AW-1:0]     bus_addr;
  logic [31:0]       bus_wdata;
  logic              trg_ext;
  logic              dac_ready = 1'b1;
  logic [NCH*DW-1:0] dac_data;
  logic [NCH-1:0]    dac_vld;
  logic [NCH-1:0]    dac_last;
  logic [NCH-1:0]    evn_per;
  logic [NCH-1:0]    evn_lst;
  logic [NCH-1:0]    sts_run;
  sample_t           lane [NCH];

  int          seed;
  bit          bp_on;
  bit          bp_now;
  int          mis_cnt;
  int          oth_cnt;
  int unsigned run_cyc;
  // model copy of tables and config
  sample_t     tbl_m [NCH][2**CWM];
  int unsigned m_siz [NCH];
  int unsigned m_ste [NCH];
  int unsigned m_off [NCH];
  bit          m_ben [NCH];
  int          m_bdl [NCH];
  int          m_bln [NCH];
  int          m_bnm [NCH];
  // expected beats, ring of 1024 per channel
  sample_t     exp_mem [NCH][1024];
  bit          exp_lst [NCH][1024];
  int          exp_wr [NCH];
  int          exp_rd [NCH];
  // event counters
  int          per_cnt [NCH];
  int          lst_cnt [NCH];
  int          dl_cnt [NCH];
  int          vld_cnt [NCH];

  asg_top dut_i (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .bus_wen   (bus_wen),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .trg_ext   (trg_ext),
    .dac_ready (dac_ready),
    .dac_data  (dac_data),
    .dac_vld   (dac_vld),
    .dac_last  (dac_last),
    .evn_per   (evn_per),
    .evn_lst   (evn_lst),
    .sts_run   (sts_run)
  );

  always #10 sto = ~sto;

  // random back-pressure, enable taken at the edge
  always @(posedge sto) begin
    bp_now = bp_on;
    #2;
    dac_ready = bp_now ? (($random(seed) & 1) != 0) : 1'b1;
  end

  // beat and event counting
  always @(posedge sto) begin
    for (int i = 0; i < NCH; i++) begin
      if (ctl_rst) begin
        exp_rd[i]  <= 0;
        per_cnt[i] <= 0;
        lst_cnt[i] <= 0;
        dl_cnt[i]  <= 0;
        vld_cnt[i] <= 0;
      end else begin
        if (dac_vld[i]) exp_rd[i] <= exp_rd[i] + 1;
        if (dac_vld[i]) vld_cnt[i] <= vld_cnt[i] + 1;
        if (evn_per[i]) per_cnt[i] <= per_cnt[i] + 1;
        if (evn_lst[i]) lst_cnt[i] <= lst_cnt[i] + 1;
        if (dac_last[i]) dl_cnt[i] <= dl_cnt[i] + 1;
      end
    end
  end

  ////////////////////////////////////////
  // lane checks, mid cycle
  ////////////////////////////////////////

  for (genvar i = 0; i < NCH; i++) begin : g_chk
    assign lane[i] = dac_data[i*DW +: DW];

    a_data: assert property (@(negedge sto) disable iff (ctl_rst)
      dac_vld[i] && (exp_rd[i] < exp_wr[i]) |-> lane[i] == exp_mem[i][exp_rd[i] & 1023])
      else begin
        mis_cnt++;
        $display("Mismatch dac_data ch%0d: expected 0x%h, got 0x%h", i,
                 exp_mem[i][exp_rd[i] & 1023], lane[i]);
      end

    // last flag only on the final burst beat
    a_last: assert property (@(negedge sto) disable iff (ctl_rst)
      dac_vld[i] && (exp_rd[i] < exp_wr[i]) |-> dac_last[i] == exp_lst[i][exp_rd[i] & 1023])
      else begin
        mis_cnt++;
        $display("Mismatch dac_last ch%0d: expected 0x%h, got 0x%h", i,
                 exp_lst[i][exp_rd[i] & 1023], dac_last[i]);
      end

    a_extra: assert property (@(negedge sto) disable iff (ctl_rst)
      dac_vld[i] |-> exp_rd[i] < exp_wr[i])
      else begin
        oth_cnt++;
        $display("channel %0d delivered a sample that was not expected", i);
      end

    // nothing moves while the DAC is not ready
    a_hold: assert property (@(negedge sto) disable iff (ctl_rst)
      !dac_ready |=> $stable(lane[i]) && !dac_vld[i])
      else begin
        oth_cnt++;
        $display("channel %0d lane changed while dac_ready was low", i);
      end
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // one pointer step, wraps modulo siz+1
  function automatic int unsigned next_ptr(int unsigned p, int unsigned ste, int unsigned siz);
    int unsigned n;
    n = p + ste + 1;
    if (n >= siz + 1) n = n - (siz + 1);
    return n;
  endfunction

  task automatic push_exp(input int ch, input sample_t s, input bit lst);
    exp_mem[ch][exp_wr[ch] & 1023] = s;
    exp_lst[ch][exp_wr[ch] & 1023] = lst;
    exp_wr[ch] = exp_wr[ch] + 1;
  endtask

  // expected stream from the channel's current config
  task automatic build_model(input int ch, input int nbeat);
    int unsigned p;
    sample_t     s;
    s = '0;
    exp_wr[ch] = exp_rd[ch];
    if (m_ben[ch]) begin
      for (int r = 0; r <= m_bnm[ch]; r++) begin
        // every period restarts at the offset
        p = m_off[ch];
        for (int k = 0; k <= m_bln[ch]; k++) begin
          if (k <= m_bdl[ch]) begin
            s = tbl_m[ch][p >> CWF];
            p = next_ptr(p, m_ste[ch], m_siz[ch]);
          end
          push_exp(ch, s, (r == m_bnm[ch]) && (k == m_bln[ch]));
        end
      end
    end else begin
      p = m_off[ch];
      repeat (nbeat) begin
        push_exp(ch, tbl_m[ch][p >> CWF], 1'b0);
        p = next_ptr(p, m_ste[ch], m_siz[ch]);
      end
    end
  endtask

  ////////////////////////////////////////
  // bus and sequencing tasks
  ////////////////////////////////////////

  task automatic bus_write(input int ch, input bit tbl, input int unsigned idx,
                           input logic [31:0] data);
    bus_wen   = 1'b1;
    bus_addr  = {ch[0], tbl, idx[AW-3:0]};
    bus_wdata = data;
    @(posedge sto);
    #2;
    bus_wen = 1'b0;
  endtask

  task automatic reg_write(input int ch, input reg_e code, input logic [31:0] data);
    bus_write(ch, 1'b0, code, data);
  endtask

  task automatic fill_table(input int ch);
    int v;
    for (int a = 0; a < 2**CWM; a++) begin
      v = $random(seed);
      tbl_m[ch][a] = v[DW-1:0];
      bus_write(ch, 1'b1, a, v);
    end
  endtask

  task automatic config_chan(input int ch, input int unsigned siz, input int unsigned ste,
                             input int unsigned off, input bit ben, input int bdl,
                             input int bln, input int bnm);
    reg_write(ch, REG_SIZ, siz);
    reg_write(ch, REG_STE, ste);
    reg_write(ch, REG_OFF, off);
    reg_write(ch, REG_BCF, 32'(ben));
    reg_write(ch, REG_BDL, bdl);
    reg_write(ch, REG_BLN, bln);
    reg_write(ch, REG_BNM, bnm);
    m_siz[ch] = siz;
    m_ste[ch] = ste;
    m_off[ch] = off;
    m_ben[ch] = ben;
    m_bdl[ch] = bdl;
    m_bln[ch] = bln;
    m_bnm[ch] = bnm;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge sto);
    #2;
  endtask

  task automatic wait_beats(input int ch, input int target);
    while (exp_rd[ch] < target) begin
      @(posedge sto);
      #2;
    end
  endtask

  task automatic wait_idle(input int ch);
    while (sts_run[ch]) begin
      @(posedge sto);
      #2;
    end
  endtask

  task automatic expect_true(input bit cond, input string what);
    assert (cond) else begin
      oth_cnt++;
      $display("%s", what);
    end
  endtask

  task automatic expect_eq(input string name, input int exp, input int got);
    assert (exp == got) else begin
      mis_cnt++;
      $display("Mismatch %s: expected 0x%h, got 0x%h", name, exp, got);
    end
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    int      b0;
    int      b1;
    int      per0;
    int      lst0;
    int      dl0;
    sample_t held;
    seed      = 32'h87173e6f;
    mis_cnt   = 0;
    oth_cnt   = 0;
    bp_on     = 1'b0;
    exp_wr    = '{default: 0};
    ctl_rst   = 1'b1;
    bus_wen   = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    trg_ext   = 1'b0;
    repeat (10) @(posedge sto);
    #2;
    ctl_rst = 1'b0;

    // reset state, then triggers without a start
    wait_cycles(2);
    expect_true(dac_vld == 0 && dac_last == 0 && evn_per == 0 && evn_lst == 0 &&
                sts_run == 0, "outputs not low after reset");
    reg_write(0, REG_CTL, 32'h4);
    reg_write(1, REG_CTL, 32'h4);
    trg_ext = 1'b1;
    wait_cycles(10);
    trg_ext = 1'b0;
    expect_eq("dac_vld beats before start", 0, vld_cnt[0] + vld_cnt[1]);
    fill_table(0);
    fill_table(1);

    // periodic, 100 entry table, step 3.5, several wraps
    config_chan(0, 32'h63FF, 32'h037F, 32'h0A40, 1'b0, 0, 0, 0);
    build_model(0, 232);
    b0 = exp_rd[0];
    reg_write(0, REG_CTL, 32'h1);
    reg_write(0, REG_CTL, 32'h4);
    wait_beats(0, b0 + 200);
    reg_write(0, REG_CTL, 32'h2);
    wait_cycles(8);
    expect_true(!sts_run[0] && !dac_vld[0], "channel 0 still running after stop");

    // finite burst, 5 data and 5 gap beats, 3 periods
    config_chan(1, 32'hFFFF, 32'h017F, 32'h1000, 1'b1, 4, 9, 2);
    build_model(1, 0);
    b1   = exp_rd[1];
    per0 = per_cnt[1];
    lst0 = lst_cnt[1];
    dl0  = dl_cnt[1];
    reg_write(1, REG_CTL, 32'h1);
    reg_write(1, REG_CTL, 32'h4);
    wait_beats(1, b1 + 30);
    wait_idle(1);
    wait_cycles(4);
    expect_eq("evn_per count ch1", 3, per_cnt[1] - per0);
    expect_eq("evn_lst count ch1", 1, lst_cnt[1] - lst0);
    expect_eq("dac_last count ch1", 1, dl_cnt[1] - dl0);
    expect_true(!sts_run[1] && !dac_vld[1], "channel 1 still running after its burst");

    // periodic under random dac_ready
    config_chan(0, 32'h63FF, 32'h037F, 32'h2280, 1'b0, 0, 0, 0);
    build_model(0, 182);
    b0    = exp_rd[0];
    bp_on = 1'b1;
    reg_write(0, REG_CTL, 32'h1);
    reg_write(0, REG_CTL, 32'h4);
    wait_beats(0, b0 + 150);
    reg_write(0, REG_CTL, 32'h2);
    wait_cycles(8);
    bp_on = 1'b0;
    wait_cycles(2);

    // both channels on one external trigger
    config_chan(0, 32'h77FF, 32'h0240, 32'h0100, 1'b0, 0, 0, 0);
    config_chan(1, 32'hC7FF, 32'h05A0, 32'h3000, 1'b0, 0, 0, 0);
    build_model(0, 132);
    build_model(1, 132);
    b0 = exp_rd[0];
    b1 = exp_rd[1];
    reg_write(0, REG_CTL, 32'h1);
    reg_write(1, REG_CTL, 32'h1);
    wait_cycles(2);
    trg_ext = 1'b1;
    wait_cycles(1);
    trg_ext = 1'b0;
    wait_beats(0, b0 + 60);
    wait_beats(1, b1 + 60);
    // stopped lane holds the last sample the model sent
    reg_write(1, REG_CTL, 32'h2);
    wait_cycles(6);
    held = exp_mem[1][(exp_rd[1] - 1) & 1023];
    wait_beats(0, b0 + 100);
    expect_eq("dac_data ch1 hold", held, lane[1]);
    expect_true(!dac_vld[1], "stopped channel 1 still marked valid");
    reg_write(0, REG_CTL, 32'h2);
    wait_cycles(8);

    $display("errors: %0d mismatches, %0d other", mis_cnt, oth_cnt);
    if (mis_cnt + oth_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // reset, tables, the five tests, then a factor of two
  initial begin
    run_cyc = 10 + 40 + 2 * 2**CWM + 300 + 100 + 2 * 200 + 200;
    #(run_cyc * 2 * 20);
    $display("watchdog expired before the tests completed");
    $display("errors: %0d mismatches, %0d other", mis_cnt, oth_cnt + 1);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
verilog/asg_pkg.sv
verilog/asg_cfg_if.sv
verilog/asg_stream_if.sv
verilog/asg_regs.sv
verilog/asg_channel.sv
verilog/asg_dac_mux.sv
verilog/asg_top.sv
dv/asg_tb.sv

//--- Makefile
# Verilator flow for the waveform generator testbench

VERILATOR ?= verilator
TOP       ?= asg_tb
FLIST     ?= flist.f
MDIR      ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SIM := $(MDIR)/V$(TOP)
SRCS := $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FLIST)

# the log decides the result, not the exit code of the binary
run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(MDIR) $(LOG)
